//--- hw/rs_pkg.sv
// shared widths, branch function codes and packed structs
// for the branch issue path (dispatch, cdb, station entry, issue, result)

package rs_pkg;

    localparam int XLEN    = 32;    // data and address width
    localparam int PRF_LEN = 6;     // physical register tag
    localparam int ROB_LEN = 5;     // reorder buffer index

    typedef enum logic [2:0] {
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL_JALR    // unconditional, always taken
    } br_func_t;

    ////////////////////
    // dispatch and cdb
    ////////////////////

    // value fields are only meaningful while the matching ready bit is set
    typedef struct packed {
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    npc;
        logic               opa_ready;
        logic [XLEN-1:0]    opa_value;
        logic [PRF_LEN-1:0] opa_tag;
        logic               opb_ready;
        logic [XLEN-1:0]    opb_value;
        logic [PRF_LEN-1:0] opb_tag;
        logic [XLEN-1:0]    offset;
        logic               jalr;           // target base from opa
        br_func_t           func;
        logic [PRF_LEN-1:0] dest_tag;
        logic [ROB_LEN-1:0] rob_idx;
        logic               pred_taken;
        logic [XLEN-1:0]    pred_target;
    } rs_dispatch_t;

    typedef struct packed {
        logic               valid;
        logic [PRF_LEN-1:0] tag;
        logic [XLEN-1:0]    value;
    } cdb_t;

    ////////////////////
    // station and unit
    ////////////////////

    // stored entry, same layout as a dispatch so a slot write is one copy
    typedef rs_dispatch_t rs_entry_t;

    typedef struct packed {
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    npc;
        logic [XLEN-1:0]    opa_value;
        logic [XLEN-1:0]    opb_value;
        logic [XLEN-1:0]    offset;
        logic               jalr;
        br_func_t           func;
        logic [PRF_LEN-1:0] dest_tag;
        logic [ROB_LEN-1:0] rob_idx;
        logic               pred_taken;
        logic [XLEN-1:0]    pred_target;
    } br_issue_t;

    typedef struct packed {
        logic               valid;
        logic [ROB_LEN-1:0] rob_idx;
        logic [PRF_LEN-1:0] dest_tag;
        logic               taken;
        logic [XLEN-1:0]    target;
        logic [XLEN-1:0]    link;       // return address, npc
        logic               mispredict;
    } br_result_t;

endpackage

//--- hw/psel_gen.sv
// lowest-index priority selector
// one-hot grant, encoded grant index and an empty flag

`timescale 1ns/1ps

module psel_gen #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         req,
    output logic [WIDTH-1:0]         gnt,
    output logic [$clog2(WIDTH)-1:0] gnt_idx,
    output logic                     empty
);

    localparam int IDX_W = $clog2(WIDTH);

    assign empty = ~|req;

    // scan from the top so the lowest set bit wins last
    always_comb begin
        gnt     = '0;
        gnt_idx = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                gnt     = '0;
                gnt[i]  = 1'b1;
                gnt_idx = IDX_W'(i);
            end
        end
    end

endmodule

//--- hw/rs_branch.sv
// branch reservation station
// free-slot choice, cdb wakeup with dispatch forwarding, issue register,
// occupancy counter and flush on commit misprediction

`timescale 1ns/1ps

module rs_branch
    import rs_pkg::*;
#(
    parameter int RS_SIZE = 8
) (
    input  logic         clock,
    input  logic         rst,
    input  logic         enable,
    input  rs_dispatch_t dispatch,
    input  cdb_t         cdb,
    input  logic         commit_mis_pred,
    output logic         full,
    output br_issue_t    issue,
    output logic         issue_valid
);

    localparam int IDX_W = $clog2(RS_SIZE);
    localparam int CNT_W = IDX_W + 1;

    rs_entry_t          entries [RS_SIZE];
    logic [RS_SIZE-1:0] free;           // 1 = slot empty
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   count_next;

    logic [RS_SIZE-1:0] wr_gnt;
    logic [IDX_W-1:0]   wr_idx;
    logic               no_free;

    logic [RS_SIZE-1:0] rdy_req;
    logic [RS_SIZE-1:0] iss_gnt;
    logic [IDX_W-1:0]   iss_idx;
    logic               none_ready;

    logic               accept;
    logic               fire;
    rs_entry_t          new_entry;
    br_issue_t          issue_d;

    ////////////////////
    // selection
    ////////////////////

    psel_gen #(.WIDTH(RS_SIZE)) u_free_sel (
        .req     (free),
        .gnt     (wr_gnt),
        .gnt_idx (wr_idx),
        .empty   (no_free)
    );

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            rdy_req[i] = ~free[i] & entries[i].opa_ready & entries[i].opb_ready;
        end
    end

    psel_gen #(.WIDTH(RS_SIZE)) u_issue_sel (
        .req     (rdy_req),
        .gnt     (iss_gnt),
        .gnt_idx (iss_idx),
        .empty   (none_ready)
    );

    assign accept     = enable & ~no_free;
    assign fire       = ~none_ready;       // unit never stalls
    assign count_next = count + CNT_W'(accept) - CNT_W'(fire);

    // dispatch entry, picking up a broadcast that lands in the same cycle
    always_comb begin
        new_entry = dispatch;
        if (cdb.valid && !dispatch.opa_ready && cdb.tag == dispatch.opa_tag) begin
            new_entry.opa_ready = 1'b1;
            new_entry.opa_value = cdb.value;
        end
        if (cdb.valid && !dispatch.opb_ready && cdb.tag == dispatch.opb_tag) begin
            new_entry.opb_ready = 1'b1;
            new_entry.opb_value = cdb.value;
        end
    end

    ////////////////////
    // entry array
    ////////////////////

    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (!free[i] && cdb.valid) begin
                if (!entries[i].opa_ready && entries[i].opa_tag == cdb.tag) begin
                    entries[i].opa_ready <= 1'b1;
                    entries[i].opa_value <= cdb.value;
                end
                if (!entries[i].opb_ready && entries[i].opb_tag == cdb.tag) begin
                    entries[i].opb_ready <= 1'b1;
                    entries[i].opb_value <= cdb.value;
                end
            end
        end
        if (accept) begin
            entries[wr_idx] <= new_entry;   // chosen slot is free, no wakeup clash
        end
    end

    ////////////////////
    // issue register
    ////////////////////

    always_comb begin
        issue_d.pc          = entries[iss_idx].pc;
        issue_d.npc         = entries[iss_idx].npc;
        issue_d.opa_value   = entries[iss_idx].opa_value;
        issue_d.opb_value   = entries[iss_idx].opb_value;
        issue_d.offset      = entries[iss_idx].offset;
        issue_d.jalr        = entries[iss_idx].jalr;
        issue_d.func        = entries[iss_idx].func;
        issue_d.dest_tag    = entries[iss_idx].dest_tag;
        issue_d.rob_idx     = entries[iss_idx].rob_idx;
        issue_d.pred_taken  = entries[iss_idx].pred_taken;
        issue_d.pred_target = entries[iss_idx].pred_target;
    end

    always_ff @(posedge clock) begin
        issue <= issue_d;
    end

    // control state, flush behaves like reset
    always_ff @(posedge clock) begin
        if (rst || commit_mis_pred) begin
            free        <= '1;
            count       <= '0;
            full        <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            free        <= (free & ~({RS_SIZE{accept}} & wr_gnt)) | ({RS_SIZE{fire}} & iss_gnt);
            count       <= count_next;
            full        <= (count_next == CNT_W'(RS_SIZE));
            issue_valid <= fire;
        end
    end

endmodule

//--- hw/branch_unit.sv
// branch resolution stage
// condition, target, link and misprediction, all registered

`timescale 1ns/1ps

module branch_unit
    import rs_pkg::*;
(
    input  logic       clock,
    input  logic       rst,
    input  logic       commit_mis_pred,
    input  br_issue_t  issue,
    input  logic       issue_valid,
    output br_result_t result
);

    logic            taken;
    logic [XLEN-1:0] taken_target;
    logic [XLEN-1:0] target;
    logic            mispredict;

    ////////////////////
    // condition
    ////////////////////

    always_comb begin
        case (issue.func)
            BEQ:      taken = (issue.opa_value == issue.opb_value);
            BNE:      taken = (issue.opa_value != issue.opb_value);
            BLT:      taken = ($signed(issue.opa_value) < $signed(issue.opb_value));
            BGE:      taken = ($signed(issue.opa_value) >= $signed(issue.opb_value));
            BLTU:     taken = (issue.opa_value < issue.opb_value);
            BGEU:     taken = (issue.opa_value >= issue.opb_value);
            JAL_JALR: taken = 1'b1;
            default:  taken = 1'b0;     // unused encoding
        endcase
    end

    ////////////////////
    // target and check
    ////////////////////

    always_comb begin
        if (issue.jalr) begin
            taken_target = (issue.opa_value + issue.offset) & ~XLEN'(1);  // clear bit 0
        end else begin
            taken_target = issue.pc + issue.offset;
        end
    end

    assign target = taken ? taken_target : issue.npc;

    // wrong direction, or right direction but wrong place
    assign mispredict = (taken != issue.pred_taken) ||
                        (taken && (target != issue.pred_target));

    always_ff @(posedge clock) begin
        if (rst || commit_mis_pred) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= issue_valid;
        end
        result.rob_idx    <= issue.rob_idx;
        result.dest_tag   <= issue.dest_tag;
        result.taken      <= taken;
        result.target     <= target;
        result.link       <= issue.npc;
        result.mispredict <= mispredict;
    end

endmodule

//--- hw/branch_issue_top.sv
// branch issue path top level
// reservation station feeding the branch resolution stage

`timescale 1ns/1ps

module branch_issue_top
    import rs_pkg::*;
#(
    parameter int RS_SIZE = 8       // power of two, 2 to 16
) (
    input  logic         clock,
    input  logic         rst,
    input  logic         enable,
    input  rs_dispatch_t dispatch,
    input  cdb_t         cdb,
    input  logic         commit_mis_pred,
    output logic         full,
    output br_result_t   result
);

    br_issue_t issue;
    logic      issue_valid;

    rs_branch #(.RS_SIZE(RS_SIZE)) u_rs_branch (
        .clock           (clock),
        .rst             (rst),
        .enable          (enable),
        .dispatch        (dispatch),
        .cdb             (cdb),
        .commit_mis_pred (commit_mis_pred),
        .full            (full),
        .issue           (issue),
        .issue_valid     (issue_valid)
    );

    branch_unit u_branch_unit (
        .clock           (clock),
        .rst             (rst),
        .commit_mis_pred (commit_mis_pred),
        .issue           (issue),
        .issue_valid     (issue_valid),
        .result          (result)
    );

endmodule

//--- sim/branch_issue_sva.sv
// assertions on the station's dispatch protocol, occupancy
// and issue to result timing

`timescale 1ns/1ps

module branch_issue_sva #(
    parameter int RS_SIZE = 8
) (
    input logic                     clock,
    input logic                     rst,
    input logic                     enable,
    input logic                     full,
    input logic                     commit_mis_pred,
    input logic [$clog2(RS_SIZE):0] count,
    input logic                     issue_valid,
    input logic                     result_valid
);

    localparam int CNT_W = $clog2(RS_SIZE) + 1;

    // dispatcher honours the full level
    enable_while_full: assert property (@(posedge clock) disable iff (rst) full |-> !enable)
        else $error("enable high while the station is full");

    count_in_range: assert property (@(posedge clock) disable iff (rst)
                                     count <= CNT_W'(RS_SIZE))
        else $error("occupancy counter above the station size");

    issue_after_flush: assert property (@(posedge clock)
                                        (rst || commit_mis_pred) |=> !issue_valid)
        else $error("issue valid after reset or flush");

    // resolution stage is one register deep
    result_timing: assert property (@(posedge clock)
                                    !(rst || commit_mis_pred) |=> result_valid == $past(issue_valid))
        else $error("result valid does not follow issue valid");

endmodule

//--- sim/branch_issue_tb.sv
// testbench for the branch issue path
// random dispatch and cdb traffic checked against a slot-level model of the
// station and the resolution stage

`timescale 1ns/1ps

module branch_issue_tb
    import rs_pkg::*;
();

    localparam int RS_SIZE      = 8;
    localparam int RESET_CYCLES = 4;
    localparam int PHASE_CYCLES = 800;
    localparam int NUM_PHASES   = 4;
    localparam int DRAIN_LIMIT  = 200;
    localparam int RUN_CYCLES   = RESET_CYCLES + PHASE_CYCLES * NUM_PHASES + DRAIN_LIMIT;

    // phases are ready only, mixed, fill up, flush heavy and drain
    localparam int P_EN   [5] = '{70, 60, 90, 50, 0};
    localparam int P_WAIT [5] = '{0, 40, 70, 50, 0};
    localparam int P_BC   [5] = '{0, 50, 10, 40, 100};
    localparam int P_FL   [5] = '{0, 1, 0, 2, 0};

    logic         clock = 1'b0;
    logic         rst;
    logic         enable;
    rs_dispatch_t dispatch;
    cdb_t         cdb;
    logic         commit_mis_pred;
    logic         full;
    br_result_t   result;

    integer seed = 77972;
    int     full_seen = 0;
    int     fwd_seen = 0;
    int     flush_seen = 0;
    int     results_seen = 0;

    // model state
    rs_dispatch_t       m_ent [RS_SIZE];
    logic [RS_SIZE-1:0] m_free;
    int                 m_count;
    logic               m_full;
    logic               m_iss_valid;
    rs_dispatch_t       m_iss;
    br_result_t         m_res;

    logic [PRF_LEN-1:0] tag_pool [$];       // tags still to be broadcast
    bit                 pending [2**PRF_LEN];

    branch_issue_top #(.RS_SIZE(RS_SIZE)) UUT (
        .clock           (clock),
        .rst             (rst),
        .enable          (enable),
        .dispatch        (dispatch),
        .cdb             (cdb),
        .commit_mis_pred (commit_mis_pred),
        .full            (full),
        .result          (result)
    );

    bind branch_issue_top branch_issue_sva #(.RS_SIZE(RS_SIZE)) u_sva (
        .clock           (clock),
        .rst             (rst),
        .enable          (enable),
        .full            (full),
        .commit_mis_pred (commit_mis_pred),
        .count           (u_rs_branch.count),
        .issue_valid     (u_rs_branch.issue_valid),
        .result_valid    (result.valid)
    );

    always #2 clock = ~clock;

    initial begin
        #(4 * (RUN_CYCLES + 100));
        $display("watchdog: the run did not finish within its time limit");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("error: time %0d ns, %s expected %h, actual %h",
                     $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    ////////////////////
    // reference model
    ////////////////////

    function automatic br_result_t resolve(input rs_dispatch_t e);
        br_result_t      r;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] sum;
        a          = e.opa_value;
        b          = e.opb_value;
        r          = '0;
        r.valid    = 1'b1;
        r.rob_idx  = e.rob_idx;
        r.dest_tag = e.dest_tag;
        r.link     = e.npc;
        case (e.func)
            BEQ:     r.taken = (a == b);
            BNE:     r.taken = (a != b);
            BLT:     r.taken = ($signed(a) < $signed(b));
            BGE:     r.taken = !($signed(a) < $signed(b));
            BLTU:    r.taken = (a < b);
            BGEU:    r.taken = !(a < b);
            default: r.taken = 1'b1;            // jal and jalr
        endcase
        sum    = (e.jalr ? a : e.pc) + e.offset;
        sum[0] = sum[0] & !e.jalr;              // jalr drops bit 0
        r.target     = r.taken ? sum : e.npc;
        r.mispredict = (r.taken != e.pred_taken) || (r.taken && r.target != e.pred_target);
        return r;
    endfunction

    function automatic rs_dispatch_t wake(input rs_dispatch_t e);
        if (cdb.valid && !e.opa_ready && e.opa_tag == cdb.tag) begin
            e.opa_ready = 1'b1;
            e.opa_value = cdb.value;
        end
        if (cdb.valid && !e.opb_ready && e.opb_tag == cdb.tag) begin
            e.opb_ready = 1'b1;
            e.opb_value = cdb.value;
        end
        return e;
    endfunction

    task automatic model_reset();
        m_free      = '1;
        m_count     = 0;
        m_full      = 1'b0;
        m_iss_valid = 1'b0;
        m_res       = '0;
    endtask

    // state after the coming rising edge
    task automatic model_edge();
        int           wr;
        int           rd;
        rs_dispatch_t nd;
        wr = -1;
        rd = -1;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (m_free[i]) wr = i;
            if (!m_free[i] && m_ent[i].opa_ready && m_ent[i].opb_ready) rd = i;
        end
        m_res       = resolve(m_iss);
        m_res.valid = m_iss_valid && !commit_mis_pred;
        nd          = wake(dispatch);
        if (commit_mis_pred) begin
            model_reset();
        end else begin
            if (rd >= 0) begin
                m_iss      = m_ent[rd];
                m_free[rd] = 1'b1;
                m_count--;
            end
            m_iss_valid = (rd >= 0);
            for (int i = 0; i < RS_SIZE; i++) begin
                if (!m_free[i]) m_ent[i] = wake(m_ent[i]);
            end
            if (enable && wr >= 0) begin
                m_ent[wr]  = nd;
                m_free[wr] = 1'b0;
                m_count++;
            end
            m_full = (m_count == RS_SIZE);
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    function automatic logic [PRF_LEN-1:0] pick_tag();
        logic [PRF_LEN-1:0] t;
        if (cdb.valid && chance(30)) begin
            fwd_seen++;
            return cdb.tag;                     // lands with the broadcast
        end
        if (tag_pool.size() > 0 && chance(50)) begin
            return tag_pool[$unsigned($random(seed)) % tag_pool.size()];
        end
        t = PRF_LEN'($random(seed));
        if (!pending[t]) begin
            pending[t] = 1'b1;
            tag_pool.push_back(t);
        end
        return t;
    endfunction

    task automatic drive_cycle(input int phase);
        int           idx;
        rs_dispatch_t d;
        cdb = '0;
        if (tag_pool.size() > 0 && chance(P_BC[phase])) begin
            idx       = $unsigned($random(seed)) % tag_pool.size();
            cdb.valid = 1'b1;
            cdb.tag   = tag_pool[idx];
            cdb.value = $random(seed);
            pending[tag_pool[idx]] = 1'b0;
            tag_pool.delete(idx);
        end
        enable          = chance(P_EN[phase]) && !m_full;
        commit_mis_pred = chance(P_FL[phase]);
        d.pc          = $random(seed) & ~32'h3;
        d.npc         = d.pc + 32'd4;
        d.offset      = ($random(seed) % 4096) & ~32'h1;
        d.opa_ready   = 1'b1;
        d.opa_value   = $random(seed);
        d.opa_tag     = PRF_LEN'($random(seed));
        d.opb_ready   = 1'b1;
        d.opb_value   = chance(25) ? d.opa_value : $random(seed);   // hit equal operands
        d.opb_tag     = PRF_LEN'($random(seed));
        d.func        = br_func_t'(3'($unsigned($random(seed)) % 7));
        d.jalr        = (d.func == JAL_JALR) && chance(50);
        d.dest_tag    = PRF_LEN'($random(seed));
        d.rob_idx     = ROB_LEN'($random(seed));
        d.pred_taken  = chance(50);
        d.pred_target = chance(50) ? d.pc + d.offset : $random(seed);
        if (enable && chance(P_WAIT[phase])) begin
            d.opa_ready = 1'b0;
            d.opa_tag   = pick_tag();
        end
        if (enable && chance(P_WAIT[phase])) begin
            d.opb_ready = 1'b0;
            d.opb_tag   = pick_tag();
        end
        dispatch = d;
        if (commit_mis_pred) flush_seen++;
    endtask

    task automatic compare_outputs();
        check_value("full", XLEN'(m_full), XLEN'(full));
        check_value("result.valid", XLEN'(m_res.valid), XLEN'(result.valid));
        if (full) full_seen++;
        if (m_res.valid) begin
            results_seen++;
            check_value("result.rob_idx", XLEN'(m_res.rob_idx), XLEN'(result.rob_idx));
            check_value("result.dest_tag", XLEN'(m_res.dest_tag), XLEN'(result.dest_tag));
            check_value("result.taken", XLEN'(m_res.taken), XLEN'(result.taken));
            check_value("result.target", m_res.target, result.target);
            check_value("result.link", m_res.link, result.link);
            check_value("result.mispredict", XLEN'(m_res.mispredict),
                        XLEN'(result.mispredict));
        end
    endtask

    task automatic step(input int phase);
        compare_outputs();
        drive_cycle(phase);
        model_edge();
        @(negedge clock);
    endtask

    initial begin
        rst             = 1'b1;
        enable          = 1'b0;
        dispatch        = '0;
        cdb             = '0;
        commit_mis_pred = 1'b0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        for (int p = 0; p < NUM_PHASES; p++) begin
            repeat (PHASE_CYCLES) step(p);
        end
        while (m_count != 0 || m_iss_valid || m_res.valid) begin
            step(NUM_PHASES);                   // drain with broadcasts only
        end
        compare_outputs();
        if (full_seen == 0 || fwd_seen == 0 || flush_seen == 0 || results_seen == 0) begin
            $display("the stimulus missed a full station, forwarding, flush or results");
            $display("Test failed");
            $fatal(1, "stimulus did not reach its goals");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

//--- all.f
hw/rs_pkg.sv
hw/psel_gen.sv
hw/rs_branch.sv
hw/branch_unit.sv
hw/branch_issue_top.sv
sim/branch_issue_sva.sv
sim/branch_issue_tb.sv

//--- Bender.yml
package:
  name: branch_issue

sources:
  # rtl, package first
  - files:
      - hw/rs_pkg.sv
      - hw/psel_gen.sv
      - hw/rs_branch.sv
      - hw/branch_unit.sv
      - hw/branch_issue_top.sv
  # testbench and bound assertions
  - target: simulation
    files:
      - sim/branch_issue_sva.sv
      - sim/branch_issue_tb.sv
